//--- verilog/axi_write_pkg.sv
`default_nettype none

package axi_write_pkg;

   localparam logic [1:0] BURST_INCR = 2'b01; // AWBURST code
   localparam int MAX_BEATS = 256;
   localparam int BOUNDARY_BYTES = 4096;
   localparam int AXI_ID_W = 4;

   // Output side sequencing
   typedef enum logic [2:0] {
      IDLE,
      PLAN,  // Capture the planned burst
      ADDR,
      DATA,
      FLUSH  // Last beat with held bytes only
   } engine_state_t;

   // AWSIZE is log2 of the bytes per beat
   function automatic logic [2:0] size_code(input int unsigned data_w);
      logic [2:0] code;
      case (data_w)
         16:      code = 3'd1;
         32:      code = 3'd2;
         64:      code = 3'd3;
         128:     code = 3'd4;
         256:     code = 3'd5;
         512:     code = 3'd6;
         1024:    code = 3'd7;
         default: code = 3'd0;
      endcase
      return code;
   endfunction

endpackage

`default_nettype wire

//--- verilog/burst_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface burst_cmd_if #(
   parameter int AXI_ADDR_W = 32,
   parameter int AXI_DATA_W = 32
);
   logic [AXI_ADDR_W-1:0]   addr;
   logic [7:0]              beats_minus_one; // AWLEN
   logic [AXI_DATA_W/8-1:0] first_strb;
   logic [AXI_DATA_W/8-1:0] last_strb;
   logic                    last_burst;
   logic                    next;            // Burst taken on AW

   modport planner (
      output addr, beats_minus_one, first_strb, last_strb, last_burst,
      input  next
   );

   modport engine (
      input  addr, beats_minus_one, first_strb, last_strb, last_burst,
      output next
   );
endinterface

`default_nettype wire

//--- verilog/transfer_planner.sv
`timescale 1ns/1ps
`default_nettype none

module transfer_planner #(
   parameter int AXI_ADDR_W = 32,
   parameter int AXI_DATA_W = 32,
   parameter int LEN_W = 16
) (
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               start,
   input  wire  [AXI_ADDR_W-1:0]             address,
   input  wire  [LEN_W-1:0]                  length,
   output logic [$clog2(AXI_DATA_W/8)-1:0]   offset,
   burst_cmd_if.planner                      cmd,
   output logic [LEN_W-1:0]                  input_words
);

   localparam int STRB_W = AXI_DATA_W / 8;
   localparam int OFF_W = $clog2(STRB_W);
   localparam int BND_W = $clog2(axi_write_pkg::BOUNDARY_BYTES);
   localparam int CALC_W = (LEN_W > 16) ? LEN_W + 1 : 18;
   localparam int RND_W = LEN_W + 1;

   logic [AXI_ADDR_W-1:0] cur_addr;
   logic [LEN_W-1:0]      bytes_left;
   logic [OFF_W-1:0]      cur_off;
   logic [OFF_W-1:0]      tail;
   logic [CALC_W-1:0]     left_ext;
   logic [CALC_W-1:0]     to_bnd;
   logic [CALC_W-1:0]     beat_cap;
   logic [CALC_W-1:0]     burst_bytes;
   logic [CALC_W-1:0]     end_off;  // Burst end, counted from its aligned base
   logic [RND_W-1:0]      len_round;

   // Pick the tightest of the three limits
   always_comb begin
      cur_off = cur_addr[OFF_W-1:0];
      left_ext = CALC_W'(bytes_left);
      to_bnd = CALC_W'(axi_write_pkg::BOUNDARY_BYTES) - CALC_W'(cur_addr[BND_W-1:0]);
      beat_cap = CALC_W'(axi_write_pkg::MAX_BEATS * STRB_W) - CALC_W'(cur_off);
      burst_bytes = left_ext;
      if (to_bnd < burst_bytes) begin
         burst_bytes = to_bnd;
      end
      if (beat_cap < burst_bytes) begin
         burst_bytes = beat_cap;
      end
      end_off = burst_bytes + CALC_W'(cur_off);
      tail = end_off[OFF_W-1:0];
   end

   assign len_round = {1'b0, length} + RND_W'(STRB_W - 1);

   assign cmd.addr = cur_addr;
   assign cmd.beats_minus_one = 8'((end_off - 1'b1) >> OFF_W);
   assign cmd.first_strb = {STRB_W{1'b1}} << cur_off;
   assign cmd.last_strb = (tail == '0) ? {STRB_W{1'b1}} : ~({STRB_W{1'b1}} << tail);
   assign cmd.last_burst = (left_ext == burst_bytes);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cur_addr <= '0;
         bytes_left <= '0;
         offset <= '0;
         input_words <= '0;
      end else if (start) begin
         cur_addr <= address;
         bytes_left <= length;
         offset <= address[OFF_W-1:0];  // Fixed for the whole transfer
         input_words <= LEN_W'(len_round >> OFF_W);
      end else if (cmd.next) begin
         // Later bursts start word aligned
         cur_addr <= cur_addr + AXI_ADDR_W'(burst_bytes);
         bytes_left <= bytes_left - LEN_W'(burst_bytes);
      end
   end

endmodule

`default_nettype wire

//--- verilog/byte_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module byte_aligner #(
   parameter int AXI_DATA_W = 32
) (
   input  wire                               clk,
   input  wire                               rst,
   input  wire  [$clog2(AXI_DATA_W/8)-1:0]   offset,
   input  wire  [AXI_DATA_W-1:0]             data_in,
   input  wire                               shift_en,
   input  wire                               flush,
   output logic [AXI_DATA_W-1:0]             data_out
);

   localparam int STRB_W = AXI_DATA_W / 8;
   localparam int OFF_W = $clog2(STRB_W);

   logic [AXI_DATA_W-1:0]   held;     // Previous input word
   logic [OFF_W:0]          drop;     // Bytes of held word that fall off
   logic [2*AXI_DATA_W-1:0] joined;

   // Output byte i takes input byte i - offset, borrowing from the held word
   always_comb begin
      drop = (OFF_W + 1)'(STRB_W) - (OFF_W + 1)'(offset);
      joined = {data_in, held} >> {drop, 3'b000};
   end

   assign data_out = joined[AXI_DATA_W-1:0]; // Offset zero gives data_in

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         held <= '0;
      end else if (shift_en) begin
         // A flush beat drains the remainder
         held <= flush ? '0 : data_in;
      end
   end

endmodule

`default_nettype wire

//--- verilog/axi_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine #(
   parameter int AXI_ADDR_W = 32,
   parameter int AXI_DATA_W = 32,
   parameter int LEN_W = 16
) (
   input  wire                                clk,
   input  wire                                rst,
   input  wire                                m_wvalid,
   output logic                               m_wready,
   output logic                               m_wlast,
   input  wire  [LEN_W-1:0]                   input_words,
   output logic                               start,
   burst_cmd_if.engine                        cmd,
   output logic                               shift_en,
   output logic                               flush,
   output logic [axi_write_pkg::AXI_ID_W-1:0] m_axi_awid,
   output logic [AXI_ADDR_W-1:0]              m_axi_awaddr,
   output logic [7:0]                         m_axi_awlen,
   output logic [2:0]                         m_axi_awsize,
   output logic [1:0]                         m_axi_awburst,
   output logic                               m_axi_awvalid,
   input  wire                                m_axi_awready,
   output logic [AXI_DATA_W/8-1:0]            m_axi_wstrb,
   output logic                               m_axi_wlast,
   output logic                               m_axi_wvalid,
   input  wire                                m_axi_wready,
   output logic                               m_axi_bready
);

   localparam int STRB_W = AXI_DATA_W / 8;

   axi_write_pkg::engine_state_t state;
   logic [7:0]        beat_cnt;
   logic [LEN_W-1:0]  in_cnt;      // Input words consumed
   logic [STRB_W-1:0] first_strb;
   logic [STRB_W-1:0] last_strb;
   logic              last_burst;
   logic              data_phase;
   logic              last_word;
   logic              beat_done;

   assign m_axi_awid = '0;
   assign m_axi_awsize = axi_write_pkg::size_code(AXI_DATA_W);
   assign m_axi_awburst = axi_write_pkg::BURST_INCR;
   assign m_axi_bready = 1'b1; // Responses are not tracked
   assign m_axi_awvalid = (state == axi_write_pkg::ADDR);
   assign cmd.next = m_axi_awvalid && m_axi_awready;
   assign start = (state == axi_write_pkg::IDLE) && m_wvalid;
   assign last_word = (in_cnt + 1'b1 == input_words);

   always_comb begin
      data_phase = (state == axi_write_pkg::DATA) || (state == axi_write_pkg::FLUSH);
      m_axi_wvalid = 1'b0;
      m_wready = 1'b0;
      m_wlast = 1'b0;
      flush = 1'b0;
      case (state)
         axi_write_pkg::DATA: begin
            m_axi_wvalid = m_wvalid;
            m_wready = m_axi_wready;
            m_wlast = last_word;
         end
         axi_write_pkg::FLUSH: begin
            m_axi_wvalid = 1'b1;  // No input needed
            flush = 1'b1;
         end
         default: ;
      endcase
      beat_done = m_axi_wvalid && m_axi_wready;
      shift_en = beat_done;
      m_axi_wlast = data_phase && (beat_cnt == m_axi_awlen);

      // Edge strobes, both on a single-beat burst
      m_axi_wstrb = '0;
      if (data_phase) begin
         m_axi_wstrb = '1;
         if (beat_cnt == 8'd0) begin
            m_axi_wstrb = m_axi_wstrb & first_strb;
         end
         if (beat_cnt == m_axi_awlen) begin
            m_axi_wstrb = m_axi_wstrb & last_strb;
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= axi_write_pkg::IDLE;
         beat_cnt <= '0;
         in_cnt <= '0;
         m_axi_awaddr <= '0;
         m_axi_awlen <= '0;
         first_strb <= '0;
         last_strb <= '0;
         last_burst <= 1'b0;
      end else begin
         case (state)
            axi_write_pkg::IDLE: begin
               if (m_wvalid) begin
                  in_cnt <= '0;
                  state <= axi_write_pkg::PLAN;
               end
            end
            axi_write_pkg::PLAN: begin  // Planner outputs have settled
               m_axi_awaddr <= cmd.addr;
               m_axi_awlen <= cmd.beats_minus_one;
               first_strb <= cmd.first_strb;
               last_strb <= cmd.last_strb;
               last_burst <= cmd.last_burst;
               state <= axi_write_pkg::ADDR;
            end
            axi_write_pkg::ADDR: begin
               if (m_axi_awready) begin
                  beat_cnt <= '0;
                  // A burst may hold only the leftover bytes
                  state <= (in_cnt == input_words) ? axi_write_pkg::FLUSH
                                                   : axi_write_pkg::DATA;
               end
            end
            axi_write_pkg::DATA, axi_write_pkg::FLUSH: begin
               if (beat_done) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (!flush) begin
                     in_cnt <= in_cnt + 1'b1;
                  end
                  if (m_axi_wlast) begin
                     state <= last_burst ? axi_write_pkg::IDLE : axi_write_pkg::PLAN;
                  end else if (state == axi_write_pkg::DATA && last_word) begin
                     state <= axi_write_pkg::FLUSH;
                  end
               end
            end
            default: state <= axi_write_pkg::IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/simple_axi_write.sv
`timescale 1ns/1ps
`default_nettype none

module simple_axi_write #(
   parameter int AXI_ADDR_W = 32,
   parameter int AXI_DATA_W = 32,
   parameter int LEN_W = 16
) (
   input  wire                                clk,
   input  wire                                rst,
   // Simple write port
   input  wire                                m_wvalid,
   output logic                               m_wready,
   input  wire  [AXI_ADDR_W-1:0]              m_waddr,
   input  wire  [AXI_DATA_W-1:0]              m_wdata,
   input  wire  [LEN_W-1:0]                   m_wlen,
   output logic                               m_wlast,
   // AXI4 write master
   output logic [axi_write_pkg::AXI_ID_W-1:0] m_axi_awid,
   output logic [AXI_ADDR_W-1:0]              m_axi_awaddr,
   output logic [7:0]                         m_axi_awlen,
   output logic [2:0]                         m_axi_awsize,
   output logic [1:0]                         m_axi_awburst,
   output logic                               m_axi_awvalid,
   input  wire                                m_axi_awready,
   output logic [AXI_DATA_W-1:0]              m_axi_wdata,
   output logic [AXI_DATA_W/8-1:0]            m_axi_wstrb,
   output logic                               m_axi_wlast,
   output logic                               m_axi_wvalid,
   input  wire                                m_axi_wready,
   input  wire                                m_axi_bvalid,
   input  wire  [1:0]                         m_axi_bresp,
   output logic                               m_axi_bready
);

   logic                            start;
   logic                            shift_en;
   logic                            flush;
   logic [$clog2(AXI_DATA_W/8)-1:0] offset;
   logic [LEN_W-1:0]                input_words;

   burst_cmd_if #(.AXI_ADDR_W(AXI_ADDR_W), .AXI_DATA_W(AXI_DATA_W)) cmd ();

   transfer_planner #(.AXI_ADDR_W(AXI_ADDR_W), .AXI_DATA_W(AXI_DATA_W), .LEN_W(LEN_W)) planner (
      .clk(clk), .rst(rst), .start(start), .address(m_waddr), .length(m_wlen),
      .offset(offset), .cmd(cmd.planner), .input_words(input_words)
   );

   byte_aligner #(.AXI_DATA_W(AXI_DATA_W)) aligner (
      .clk(clk), .rst(rst), .offset(offset), .data_in(m_wdata),
      .shift_en(shift_en), .flush(flush), .data_out(m_axi_wdata)
   );

   axi_write_engine #(.AXI_ADDR_W(AXI_ADDR_W), .AXI_DATA_W(AXI_DATA_W), .LEN_W(LEN_W)) engine (
      .clk(clk), .rst(rst), .m_wvalid(m_wvalid), .m_wready(m_wready), .m_wlast(m_wlast),
      .input_words(input_words), .start(start), .cmd(cmd.engine),
      .shift_en(shift_en), .flush(flush),
      .m_axi_awid(m_axi_awid), .m_axi_awaddr(m_axi_awaddr), .m_axi_awlen(m_axi_awlen),
      .m_axi_awsize(m_axi_awsize), .m_axi_awburst(m_axi_awburst),
      .m_axi_awvalid(m_axi_awvalid), .m_axi_awready(m_axi_awready),
      .m_axi_wstrb(m_axi_wstrb), .m_axi_wlast(m_axi_wlast), .m_axi_wvalid(m_axi_wvalid),
      .m_axi_wready(m_axi_wready), .m_axi_bready(m_axi_bready)
   );

endmodule

`default_nettype wire

//--- test/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32,
   parameter int MEM_BYTES = 65536,
   parameter int SEED = 1764
) (
   input  wire                 clk,
   input  wire                 rst,
   input  wire  [ADDR_W-1:0]   awaddr,
   input  wire  [7:0]          awlen,
   input  wire  [2:0]          awsize,
   input  wire  [1:0]          awburst,
   input  wire                 awvalid,
   output logic                awready,
   input  wire  [DATA_W-1:0]   wdata,
   input  wire  [DATA_W/8-1:0] wstrb,
   input  wire                 wlast,
   input  wire                 wvalid,
   output logic                wready,
   output logic                bvalid,
   output logic [1:0]          bresp,
   input  wire                 bready,
   output logic                rule_err
);

   localparam int STRB_W = DATA_W / 8;

   logic [7:0]        mem [0:MEM_BYTES-1];
   integer            seed;
   logic              busy;       // AW taken, beats still owed
   logic [ADDR_W-1:0] base;       // Aligned start of the open burst
   logic [7:0]        len;
   logic [8:0]        beat;
   logic              b_due;
   logic              err_seen;
   logic [ADDR_W-1:0] last_byte;
   logic [ADDR_W-1:0] beat_addr;

   task automatic flag_violation(input string what);
      $display("AXI rule broken at %0t: %s", $time, what);
      err_seen = 1'b1;
   endtask

   initial begin
      seed = SEED;
      awready = 1'b0;
      wready = 1'b0;
      bvalid = 1'b0;
      bresp = 2'b00;
      rule_err = 1'b0;
      err_seen = 1'b0;
      busy = 1'b0;
      beat = '0;
      for (int a = 0; a < MEM_BYTES; a++) begin
         mem[a] = 8'(a ^ (a >> 8) ^ 'h3c);
      end
      forever begin
         @(posedge clk);
         b_due = 1'b0;
         if (!rst && bvalid && !bready) flag_violation("write response not accepted");
         if (!rst && wvalid && wready) begin
            if (!busy) begin
               flag_violation("write data without an open burst");
            end else begin
               beat_addr = base + ADDR_W'(beat) * STRB_W;
               for (int j = 0; j < STRB_W; j++) begin
                  if (wstrb[j]) mem[(beat_addr + ADDR_W'(j)) % MEM_BYTES] = wdata[8*j +: 8];
               end
               if (wlast != (beat == len)) flag_violation("wlast does not mark the last beat");
               if (wlast) begin
                  busy = 1'b0;
                  b_due = 1'b1;
               end
               beat = beat + 1'b1;
            end
         end
         if (!rst && awvalid && awready) begin
            last_byte = (awaddr & ~ADDR_W'(STRB_W - 1)) + (ADDR_W'(awlen) + 1) * STRB_W - 1;
            if (busy) flag_violation("new address while a burst is open");
            if (awburst != 2'b01) flag_violation("burst type is not INCR");
            if ((1 << awsize) != STRB_W) flag_violation("beat size is not the bus width");
            if (awaddr[ADDR_W-1:12] != last_byte[ADDR_W-1:12]) begin
               flag_violation("burst crosses a 4 KB boundary");
            end
            base = awaddr & ~ADDR_W'(STRB_W - 1);
            len = awlen;
            beat = '0;
            busy = 1'b1;
         end
         #1;
         rule_err = err_seen;
         bvalid = b_due;  // OKAY response one cycle after wlast
         if (rst) begin
            awready = 1'b0;
            wready = 1'b0;
         end else begin
            awready = ($random(seed) & 3) != 0;
            wready = ($random(seed) & 7) > 1;
         end
      end
   end

endmodule

`default_nettype wire

//--- test/tb_simple_axi_write.sv
`timescale 1ns/1ps
`default_nettype none

module tb_simple_axi_write;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int LEN_W = 16;
   localparam int STRB_W = DATA_W / 8;
   localparam int MEM_BYTES = 65536;
   localparam int NUM_XFERS = 40;
   localparam int XFER_TIMEOUT = 20000;  // Cycles per transfer
   localparam int MAX_BURSTS = 8;

   logic                               clk;
   logic                               rst;
   logic                               m_wvalid;
   logic                               m_wready;
   logic [ADDR_W-1:0]                  m_waddr;
   logic [DATA_W-1:0]                  m_wdata;
   logic [LEN_W-1:0]                   m_wlen;
   logic                               m_wlast;
   logic [axi_write_pkg::AXI_ID_W-1:0] m_axi_awid;
   logic [ADDR_W-1:0]                  m_axi_awaddr;
   logic [7:0]                         m_axi_awlen;
   logic [2:0]                         m_axi_awsize;
   logic [1:0]                         m_axi_awburst;
   logic                               m_axi_awvalid;
   logic                               m_axi_awready;
   logic [DATA_W-1:0]                  m_axi_wdata;
   logic [STRB_W-1:0]                  m_axi_wstrb;
   logic                               m_axi_wlast;
   logic                               m_axi_wvalid;
   logic                               m_axi_wready;
   logic                               m_axi_bvalid;
   logic [1:0]                         m_axi_bresp;
   logic                               m_axi_bready;
   logic                               rule_err;

   integer            seed;
   logic [7:0]        shadow [0:MEM_BYTES-1];
   logic [7:0]        xfer_data [0:2047];
   logic [ADDR_W-1:0] exp_addr [0:MAX_BURSTS-1];
   logic [7:0]        exp_len [0:MAX_BURSTS-1];
   int                exp_bytes [0:MAX_BURSTS-1];
   int                exp_count = 0;
   int                burst_base = 0;  // Bursts seen before this transfer
   int                aw_total = 0;
   int                w_total = 0;
   int                beat = 0;

   simple_axi_write #(.AXI_ADDR_W(ADDR_W), .AXI_DATA_W(DATA_W), .LEN_W(LEN_W)) dut (
      .clk(clk), .rst(rst), .m_wvalid(m_wvalid), .m_wready(m_wready),
      .m_waddr(m_waddr), .m_wdata(m_wdata), .m_wlen(m_wlen), .m_wlast(m_wlast),
      .m_axi_awid(m_axi_awid), .m_axi_awaddr(m_axi_awaddr), .m_axi_awlen(m_axi_awlen),
      .m_axi_awsize(m_axi_awsize), .m_axi_awburst(m_axi_awburst),
      .m_axi_awvalid(m_axi_awvalid), .m_axi_awready(m_axi_awready),
      .m_axi_wdata(m_axi_wdata), .m_axi_wstrb(m_axi_wstrb), .m_axi_wlast(m_axi_wlast),
      .m_axi_wvalid(m_axi_wvalid), .m_axi_wready(m_axi_wready),
      .m_axi_bvalid(m_axi_bvalid), .m_axi_bresp(m_axi_bresp), .m_axi_bready(m_axi_bready)
   );

   axi_mem_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .MEM_BYTES(MEM_BYTES), .SEED(1764)) slave (
      .clk(clk), .rst(rst), .awaddr(m_axi_awaddr), .awlen(m_axi_awlen),
      .awsize(m_axi_awsize), .awburst(m_axi_awburst), .awvalid(m_axi_awvalid),
      .awready(m_axi_awready), .wdata(m_axi_wdata), .wstrb(m_axi_wstrb),
      .wlast(m_axi_wlast), .wvalid(m_axi_wvalid), .wready(m_axi_wready),
      .bvalid(m_axi_bvalid), .bresp(m_axi_bresp), .bready(m_axi_bready),
      .rule_err(rule_err)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at %0t: %s", $time, msg);
      $display("Something failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic abort_run(input string msg);
      $display("%s (at %0t)", msg, $time);
      $display("Something failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_byte(input logic [ADDR_W-1:0] addr, input logic [7:0] got,
                             input logic [7:0] want);
      if (got !== want) begin
         report_mismatch($sformatf("byte 0x%0h is 0x%02h, expected 0x%02h", addr, got, want));
      end
   endtask

   task automatic check_burst(input logic [ADDR_W-1:0] got_addr, input logic [7:0] got_len,
                              input logic [ADDR_W-1:0] want_addr, input logic [7:0] want_len);
      if (got_addr !== want_addr || got_len !== want_len) begin
         report_mismatch($sformatf("burst 0x%0h len %0d, expected 0x%0h len %0d",
                                   got_addr, got_len, want_addr, want_len));
      end
   endtask

   task automatic check_id(input logic [axi_write_pkg::AXI_ID_W-1:0] got,
                           input logic [axi_write_pkg::AXI_ID_W-1:0] want);
      if (got !== want) begin
         report_mismatch($sformatf("awid is %0d, expected %0d", got, want));
      end
   endtask

   task automatic check_strb(input int beat_no, input logic [STRB_W-1:0] got,
                             input logic [STRB_W-1:0] want);
      if (got !== want) begin
         report_mismatch($sformatf("wstrb on beat %0d is %b, expected %b", beat_no, got, want));
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic want);
      if (got !== want) report_mismatch($sformatf("%s is %b, expected %b", what, got, want));
   endtask

   task automatic check_words(input logic [LEN_W-1:0] got, input logic [LEN_W-1:0] want);
      if (got !== want) begin
         report_mismatch($sformatf("%0d m_wready pulses, expected %0d", got, want));
      end
   endtask

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic logic [DATA_W-1:0] pack_word(input int idx);
      logic [DATA_W-1:0] w;
      for (int j = 0; j < STRB_W; j++) begin
         w[8*j +: 8] = xfer_data[idx * STRB_W + j];
      end
      return w;
   endfunction

   // Split by bytes left, distance to 4 KB and 256 beats
   task automatic plan_bursts(input logic [ADDR_W-1:0] addr, input int len);
      logic [ADDR_W-1:0] cur;
      int left;
      int take;
      int lane;
      cur = addr;
      left = len;
      exp_count = 0;
      while (left > 0) begin
         lane = int'(cur % STRB_W);
         take = left;
         if (4096 - int'(cur[11:0]) < take) take = 4096 - int'(cur[11:0]);
         if (256 * STRB_W - lane < take) take = 256 * STRB_W - lane;
         exp_addr[exp_count] = cur;
         exp_bytes[exp_count] = take;
         exp_len[exp_count] = 8'((lane + take - 1) / STRB_W);
         cur = cur + ADDR_W'(take);
         left = left - take;
         exp_count++;
      end
   endtask

   task automatic run_transfer(input logic [ADDR_W-1:0] addr, input int len);
      int words;
      int word_idx;
      int bursts_done;
      int cycles;
      words = (len + STRB_W - 1) / STRB_W;
      word_idx = 0;
      bursts_done = 0;
      cycles = 0;
      m_waddr = addr;
      m_wlen = LEN_W'(len);
      m_wdata = pack_word(0);
      m_wvalid = 1'b1;
      while (bursts_done < exp_count) begin
         @(posedge clk);
         if (m_wready) begin
            check_bit("m_wlast", m_wlast, word_idx == words - 1);
            word_idx++;
         end
         if (m_axi_wvalid && m_axi_wready && m_axi_wlast) bursts_done++;
         cycles++;
         if (cycles > XFER_TIMEOUT) abort_run("Timeout waiting for the transfer to finish");
         #1;
         m_wdata = pack_word(word_idx);
         if (bursts_done == exp_count) m_wvalid = 1'b0;
      end
      check_words(LEN_W'(word_idx), LEN_W'(words));
      repeat (2) @(posedge clk);  // Idle gap before the next request
      #1;
   endtask

   always @(posedge clk) begin : bus_monitor
      int idx;
      logic [ADDR_W-1:0] beat_base;
      logic [STRB_W-1:0] want;
      if (!rst) begin
         if (rule_err) abort_run("The AXI slave saw a broken burst rule");
         if (m_axi_wvalid && m_axi_wready) begin
            idx = w_total - burst_base;
            if (idx >= aw_total - burst_base) begin
               abort_run("Write data arrived before its burst address");
            end else begin
               beat_base = (exp_addr[idx] & ~ADDR_W'(STRB_W - 1)) + ADDR_W'(beat * STRB_W);
               for (int j = 0; j < STRB_W; j++) begin
                  want[j] = (beat_base + ADDR_W'(j) >= exp_addr[idx]) &&
                            (beat_base + ADDR_W'(j) < exp_addr[idx] + ADDR_W'(exp_bytes[idx]));
               end
               check_strb(beat, m_axi_wstrb, want);
               check_bit("wlast", m_axi_wlast, beat == exp_len[idx]);
               if (m_axi_wlast) begin
                  w_total++;
                  beat = 0;
               end else begin
                  beat++;
               end
            end
         end
         if (m_axi_awvalid && m_axi_awready) begin
            idx = aw_total - burst_base;
            if (idx >= exp_count) abort_run("More bursts issued than the transfer needs");
            check_burst(m_axi_awaddr, m_axi_awlen, exp_addr[idx], exp_len[idx]);
            check_id(m_axi_awid, '0);
            aw_total++;
         end
      end
   end

   initial begin : stimulus
      logic [ADDR_W-1:0] addr;
      int len;
      int base_i;
      seed = 1764;
      rst = 1'b1;
      m_wvalid = 1'b0;
      m_waddr = '0;
      m_wdata = '0;
      m_wlen = '0;
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;
      for (int a = 0; a < MEM_BYTES; a++) begin
         shadow[a] = slave.mem[a];
      end
      for (int t = 0; t < NUM_XFERS; t++) begin
         case (rand_below(3))
            0: addr = ADDR_W'(rand_below(62000));
            1: addr = ADDR_W'((1 + rand_below(14)) * 4096 - rand_below(64)); // Near 4 KB
            default: addr = ADDR_W'(rand_below(15000) * STRB_W);
         endcase
         case (rand_below(4))
            0: len = 1 + rand_below(4);
            1: len = STRB_W * (1 + rand_below(375));
            default: len = 1 + rand_below(1500);
         endcase
         if (t == 0) len = 1;
         for (int i = 0; i < len + 2 * STRB_W; i++) begin
            xfer_data[i] = 8'($random(seed));  // Tail past len is filler
         end
         plan_bursts(addr, len);
         burst_base = aw_total;
         run_transfer(addr, len);
         base_i = int'(addr);
         for (int i = 0; i < len; i++) begin
            shadow[base_i + i] = xfer_data[i];
         end
         for (int a = base_i - 8; a < base_i + len + 8; a++) begin
            if (a >= 0 && a < MEM_BYTES) check_byte(ADDR_W'(a), slave.mem[a], shadow[a]);
         end
      end
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
verilog/axi_write_pkg.sv
verilog/burst_cmd_if.sv
verilog/transfer_planner.sv
verilog/byte_aligner.sv
verilog/axi_write_engine.sv
verilog/simple_axi_write.sv
test/axi_mem_model.sv
test/tb_simple_axi_write.sv
